// ==== hdl/rename_pkg.sv ====
package rename_pkg;

    // ====================================================================
    // register file sizes
    // ====================================================================

    // architectural and physical register counts.
    localparam int unsigned ARF_DEPTH = 8;
    localparam int unsigned PRF_DEPTH = 24;

    // index widths.
    localparam int unsigned ARF_IDX = $clog2(ARF_DEPTH);
    localparam int unsigned PRF_IDX = $clog2(PRF_DEPTH);

    // ====================================================================
    // machine width
    // ====================================================================

    // lanes per cycle, rename and commit alike.
    localparam int unsigned ID_WIDTH = 2;
    // a lane count needs one bit more.
    localparam int unsigned ID_WIDTH_IDX = $clog2(ID_WIDTH);

    // ====================================================================
    // free queue
    // ====================================================================

    localparam int unsigned FREELIST_DEPTH = PRF_DEPTH - ARF_DEPTH;
    localparam int unsigned FREELIST_IDX = $clog2(FREELIST_DEPTH);

endpackage

// ==== hdl/free_list.sv ====
`timescale 1ns/10ps

module free_list (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 backend_flush,

    input  logic [rename_pkg::ID_WIDTH-1:0]      rename_valid,
    input  logic [rename_pkg::ID_WIDTH-1:0]      stale_valid,
    input  logic [rename_pkg::PRF_IDX-1:0]       stale_idx [rename_pkg::ID_WIDTH],

    output logic [rename_pkg::PRF_IDX-1:0]       free_idx [rename_pkg::ID_WIDTH],
    output logic                                 rename_ready
);

    logic [rename_pkg::PRF_IDX-1:0]        queue [rename_pkg::FREELIST_DEPTH];
    logic [rename_pkg::FREELIST_IDX-1:0]   wr_ptr;
    logic [rename_pkg::FREELIST_IDX-1:0]   wr_ptr_nxt;
    logic [rename_pkg::FREELIST_IDX-1:0]   rd_ptr;
    logic [rename_pkg::FREELIST_IDX:0]     count;
    logic [rename_pkg::FREELIST_IDX:0]     count_nxt;

    logic [rename_pkg::ID_WIDTH_IDX:0]     n_alloc;
    logic [rename_pkg::ID_WIDTH_IDX:0]     n_ret;
    logic [rename_pkg::ID_WIDTH_IDX:0]     ret_off [rename_pkg::ID_WIDTH];
    logic                                  accept;

    // ====================================================================
    // lane counts
    // ====================================================================

    always_comb begin
        n_alloc = '0;
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            if (rename_valid[i]) begin
                n_alloc = n_alloc + 1'b1;
            end
        end
    end

    // returned lanes pack behind the write pointer in lane order.
    always_comb begin
        n_ret = '0;
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            ret_off[i] = n_ret;
            if (stale_valid[i]) begin
                n_ret = n_ret + 1'b1;
            end
        end
    end

    assign rename_ready = (count >= (rename_pkg::FREELIST_IDX + 1)'(n_alloc));
    assign accept = (|rename_valid) && rename_ready && !backend_flush;

    assign wr_ptr_nxt = rename_pkg::FREELIST_IDX'(wr_ptr + n_ret);
    assign count_nxt = accept ? count + n_ret - n_alloc : count + n_ret;

    // ====================================================================
    // pointers and count
    // ====================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= (rename_pkg::FREELIST_IDX + 1)'(rename_pkg::FREELIST_DEPTH);
        end else begin
            wr_ptr <= wr_ptr_nxt;
            if (backend_flush) begin
                // everything allocated since the last commit sits between
                // the write pointer and the old read pointer.
                rd_ptr <= wr_ptr_nxt;
                count <= (rename_pkg::FREELIST_IDX + 1)'(rename_pkg::FREELIST_DEPTH);
            end else begin
                if (accept) begin
                    rd_ptr <= rename_pkg::FREELIST_IDX'(rd_ptr + n_alloc);
                end
                count <= count_nxt;
            end
        end
    end

    // ====================================================================
    // queue storage
    // ====================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::FREELIST_DEPTH; i++) begin
                queue[i] <= rename_pkg::PRF_IDX'(rename_pkg::ARF_DEPTH + i);
            end
        end else begin
            for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
                if (stale_valid[i]) begin
                    queue[rename_pkg::FREELIST_IDX'(wr_ptr + ret_off[i])] <= stale_idx[i];
                end
            end
        end
    end

    // next entries from the read pointer.
    for (genvar i = 0; i < rename_pkg::ID_WIDTH; i++) begin : g_free
        assign free_idx[i] = queue[rename_pkg::FREELIST_IDX'(rd_ptr + i)];
    end

endmodule

// ==== hdl/rename_table.sv ====
`timescale 1ns/10ps

module rename_table (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 backend_flush,

    input  logic [rename_pkg::ID_WIDTH-1:0]      rename_valid,
    input  logic [rename_pkg::ARF_IDX-1:0]       rename_dest [rename_pkg::ID_WIDTH],
    input  logic [rename_pkg::ARF_IDX-1:0]       rename_src [rename_pkg::ID_WIDTH],
    input  logic                                 rename_ready,

    input  logic [rename_pkg::PRF_IDX-1:0]       free_idx [rename_pkg::ID_WIDTH],
    input  logic [rename_pkg::PRF_IDX-1:0]       arch_map [rename_pkg::ARF_DEPTH],

    output logic [rename_pkg::PRF_IDX-1:0]       rename_phys_dest [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::PRF_IDX-1:0]       rename_phys_src [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::PRF_IDX-1:0]       rename_stale [rename_pkg::ID_WIDTH]
);

    logic [rename_pkg::PRF_IDX-1:0]   spec_map [rename_pkg::ARF_DEPTH];
    logic                             accept;

    assign accept = (|rename_valid) && rename_ready && !backend_flush;

    // ====================================================================
    // destination allocation
    // ====================================================================

    // each lane takes the next unused free entry.
    always_comb begin : alloc
        logic [rename_pkg::ID_WIDTH_IDX:0] used;
        used = '0;
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            rename_phys_dest[i] = free_idx[rename_pkg::ID_WIDTH_IDX'(used)];
            if (rename_valid[i]) begin
                used = used + 1'b1;
            end
        end
    end

    // ====================================================================
    // source and stale lookup
    // ====================================================================

    always_comb begin
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            rename_phys_src[i] = spec_map[rename_src[i]];
            rename_stale[i] = spec_map[rename_dest[i]];
            // older lanes in the group override the map, youngest last.
            for (int j = 0; j < i; j++) begin
                if (rename_valid[j] && (rename_dest[j] == rename_src[i])) begin
                    rename_phys_src[i] = rename_phys_dest[j];
                end
                if (rename_valid[j] && (rename_dest[j] == rename_dest[i])) begin
                    rename_stale[i] = rename_phys_dest[j];
                end
            end
        end
    end

    // ====================================================================
    // speculative map
    // ====================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARF_DEPTH; i++) begin
                spec_map[i] <= rename_pkg::PRF_IDX'(i);
            end
        end else if (backend_flush) begin
            for (int i = 0; i < rename_pkg::ARF_DEPTH; i++) begin
                spec_map[i] <= arch_map[i];
            end
        end else if (accept) begin
            // later lane wins on a shared destination.
            for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
                if (rename_valid[i]) begin
                    spec_map[rename_dest[i]] <= rename_phys_dest[i];
                end
            end
        end
    end

endmodule

// ==== hdl/retire_table.sv ====
`timescale 1ns/10ps

module retire_table (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [rename_pkg::ID_WIDTH-1:0]      commit_valid,
    input  logic [rename_pkg::ARF_IDX-1:0]       commit_arch [rename_pkg::ID_WIDTH],
    input  logic [rename_pkg::PRF_IDX-1:0]       commit_phys [rename_pkg::ID_WIDTH],

    output logic [rename_pkg::ID_WIDTH-1:0]      stale_valid,
    output logic [rename_pkg::PRF_IDX-1:0]       stale_idx [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::PRF_IDX-1:0]       arch_map [rename_pkg::ARF_DEPTH]
);

    logic [rename_pkg::PRF_IDX-1:0]   retire_map [rename_pkg::ARF_DEPTH];
    logic [rename_pkg::PRF_IDX-1:0]   map_nxt [rename_pkg::ARF_DEPTH];

    // ====================================================================
    // committed map
    // ====================================================================

    always_comb begin
        map_nxt = retire_map;
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            if (commit_valid[i]) begin
                map_nxt[commit_arch[i]] = commit_phys[i];
            end
        end
    end

    // flush restores from the map with this cycle's commits applied.
    assign arch_map = map_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARF_DEPTH; i++) begin
                retire_map[i] <= rename_pkg::PRF_IDX'(i);
            end
        end else begin
            retire_map <= map_nxt;
        end
    end

    // ====================================================================
    // stale registers
    // ====================================================================

    assign stale_valid = commit_valid;

    always_comb begin
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            stale_idx[i] = retire_map[commit_arch[i]];
            // an older lane in the group already replaced this mapping.
            for (int j = 0; j < i; j++) begin
                if (commit_valid[j] && (commit_arch[j] == commit_arch[i])) begin
                    stale_idx[i] = commit_phys[j];
                end
            end
        end
    end

endmodule

// ==== hdl/rename_core.sv ====
`timescale 1ns/10ps

module rename_core (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 backend_flush,

    // rename group.
    input  logic [rename_pkg::ID_WIDTH-1:0]      rename_valid,
    input  logic [rename_pkg::ARF_IDX-1:0]       rename_dest [rename_pkg::ID_WIDTH],
    input  logic [rename_pkg::ARF_IDX-1:0]       rename_src [rename_pkg::ID_WIDTH],

    // commit group, program order.
    input  logic [rename_pkg::ID_WIDTH-1:0]      commit_valid,
    input  logic [rename_pkg::ARF_IDX-1:0]       commit_arch [rename_pkg::ID_WIDTH],
    input  logic [rename_pkg::PRF_IDX-1:0]       commit_phys [rename_pkg::ID_WIDTH],

    output logic                                 rename_ready,
    output logic [rename_pkg::PRF_IDX-1:0]       rename_phys_dest [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::PRF_IDX-1:0]       rename_phys_src [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::PRF_IDX-1:0]       rename_stale [rename_pkg::ID_WIDTH]
);

    logic [rename_pkg::PRF_IDX-1:0]   free_idx [rename_pkg::ID_WIDTH];
    logic [rename_pkg::ID_WIDTH-1:0]  stale_valid;
    logic [rename_pkg::PRF_IDX-1:0]   stale_idx [rename_pkg::ID_WIDTH];
    logic [rename_pkg::PRF_IDX-1:0]   arch_map [rename_pkg::ARF_DEPTH];

    free_list u_free_list (
        .clk           (clk),
        .rst           (rst),
        .backend_flush (backend_flush),
        .rename_valid  (rename_valid),
        .stale_valid   (stale_valid),
        .stale_idx     (stale_idx),
        .free_idx      (free_idx),
        .rename_ready  (rename_ready)
    );

    rename_table u_rename_table (
        .clk              (clk),
        .rst              (rst),
        .backend_flush    (backend_flush),
        .rename_valid     (rename_valid),
        .rename_dest      (rename_dest),
        .rename_src       (rename_src),
        .rename_ready     (rename_ready),
        .free_idx         (free_idx),
        .arch_map         (arch_map),
        .rename_phys_dest (rename_phys_dest),
        .rename_phys_src  (rename_phys_src),
        .rename_stale     (rename_stale)
    );

    retire_table u_retire_table (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_arch  (commit_arch),
        .commit_phys  (commit_phys),
        .stale_valid  (stale_valid),
        .stale_idx    (stale_idx),
        .arch_map     (arch_map)
    );

endmodule

// ==== verif/rename_tests.svh ====
`ifndef RENAME_TESTS_SVH
`define RENAME_TESTS_SVH

function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

task automatic open_test(input string name);
    cur_test = name;
    test_errs = 0;
endtask

task automatic close_test();
    if (test_errs == 0) begin
        $display("test %s: ok", cur_test);
        tests_passed++;
    end else begin
        $display("test %s: %0d errors", cur_test, test_errs);
        tests_failed++;
    end
endtask

// ======================================================================
// directed tests
// ======================================================================

task automatic check_reset_state();
    open_test("reset_state");
    run_cycle(1'b0, 2, 3, 5, 1, 6, 0);
    if (rename_phys_dest[0] !== 8) report_mismatch("first dest lane 0", 8, rename_phys_dest[0]);
    if (rename_phys_dest[1] !== 9) report_mismatch("first dest lane 1", 9, rename_phys_dest[1]);
    if (rename_stale[0] !== 3) report_mismatch("first stale lane 0", 3, rename_stale[0]);
    if (rename_stale[1] !== 5) report_mismatch("first stale lane 1", 5, rename_stale[1]);
    if (rename_phys_src[0] !== 1) report_mismatch("reset src lane 0", 1, rename_phys_src[0]);
    if (rename_phys_src[1] !== 6) report_mismatch("reset src lane 1", 6, rename_phys_src[1]);
    close_test();
endtask

task automatic check_group_bypass();
    int lane0_dest;
    int shared_dest;
    open_test("group_bypass");
    // lane 1 reads lane 0's destination.
    lane0_dest = model_free[0];
    run_cycle(1'b0, 2, 4, 2, 0, 4, 0);
    if (rename_phys_src[1] !== lane0_dest) begin
        report_mismatch("lane 1 src bypass", lane0_dest, rename_phys_src[1]);
    end
    lane0_dest = model_free[0];
    shared_dest = model_free[1];
    run_cycle(1'b0, 2, 6, 6, 1, 2, 0);
    if (rename_stale[1] !== lane0_dest) begin
        report_mismatch("lane 1 stale bypass", lane0_dest, rename_stale[1]);
    end
    run_cycle(1'b0, 1, 0, 0, 6, 0, 0);
    if (rename_phys_src[0] !== shared_dest) begin
        report_mismatch("younger lane wins", shared_dest, rename_phys_src[0]);
    end
    close_test();
endtask

task automatic exhaust_free_list();
    int k;
    open_test("exhaustion");
    k = 0;
    while (model_free.size() > 2) begin
        run_cycle(1'b0, 2, k % 8, (k + 3) % 8, (k + 5) % 8, (k + 1) % 8, 0);
        k++;
    end
    if (model_free.size() == 2) begin
        run_cycle(1'b0, 1, 7, 0, 2, 0, 0);
    end
    // one register left.
    run_cycle(1'b0, 2, 1, 2, 3, 4, 0);
    if (rename_ready !== 1'b0) report_mismatch("ready, two lanes, one free", 0, rename_ready);
    run_cycle(1'b0, 1, 5, 0, 5, 0, 0);
    if (rename_ready !== 1'b1) report_mismatch("ready, one lane, one free", 1, rename_ready);
    for (int i = 0; i < 3; i++) begin
        run_cycle(1'b0, 1, 5, 0, 5, 0, 0);
        if (rename_ready !== 1'b0) report_mismatch("ready with none free", 0, rename_ready);
        if (rename_phys_src[0] !== model_spec[5]) begin
            report_mismatch("held src", model_spec[5], rename_phys_src[0]);
        end
    end
    close_test();
endtask

task automatic commit_and_reuse();
    int first_freed;
    int freed;
    open_test("commit_reuse");
    first_freed = model_arch[inflight_arch[0]];
    while (inflight_arch.size() > 0) begin
        run_cycle(1'b0, 0, 0, 0, 0, 0, 2);
    end
    run_cycle(1'b0, 2, 2, 7, 3, 1, 0);
    if (rename_phys_dest[0] !== first_freed) begin
        report_mismatch("first reused dest", first_freed, rename_phys_dest[0]);
    end
    for (int k = 1; k < 8; k++) begin
        run_cycle(1'b0, 2, k % 8, (k + 4) % 8, (k + 2) % 8, k % 8, 0);
        if (rename_ready !== 1'b1) report_mismatch("ready during refill", 1, rename_ready);
    end
    // a freed register shows up one cycle after its commit.
    freed = model_arch[inflight_arch[0]];
    run_cycle(1'b0, 1, 6, 0, 6, 0, 1);
    if (rename_ready !== 1'b0) report_mismatch("ready in commit cycle", 0, rename_ready);
    run_cycle(1'b0, 1, 6, 0, 6, 0, 0);
    if (rename_phys_dest[0] !== freed) report_mismatch("dest after commit", freed,
                                                       rename_phys_dest[0]);
    close_test();
endtask

task automatic flush_recovery();
    int first_free;
    open_test("flush");
    for (int k = 0; k < 3; k++) begin
        run_cycle(1'b0, 0, 0, 0, 0, 0, 2);
    end
    run_cycle(1'b0, 2, 1, 4, 0, 1, 0);
    run_cycle(1'b0, 2, 3, 1, 4, 2, 0);
    // commit in the flush cycle, rename request dropped.
    run_cycle(1'b1, 2, 4, 5, 6, 7, 2);
    first_free = model_free[0];
    for (int k = 0; k < 8; k++) begin
        run_cycle(1'b0, 2, (2 * k + 3) % 8, (2 * k + 6) % 8, (2 * k) % 8, (2 * k + 1) % 8, 0);
        if (rename_ready !== 1'b1) report_mismatch("ready after flush", 1, rename_ready);
        if (k == 0) begin
            if (rename_phys_dest[0] !== first_free) begin
                report_mismatch("rewound dest", first_free, rename_phys_dest[0]);
            end
            if (rename_phys_src[0] !== model_arch[0]) begin
                report_mismatch("restored src 0", model_arch[0], rename_phys_src[0]);
            end
            if (rename_phys_src[1] !== model_arch[1]) begin
                report_mismatch("restored src 1", model_arch[1], rename_phys_src[1]);
            end
        end
    end
    run_cycle(1'b0, 1, 2, 0, 2, 0, 0);
    if (rename_ready !== 1'b0) report_mismatch("ready after 16 allocations", 0, rename_ready);
    run_cycle(1'b1, 0, 0, 0, 0, 0, 0);
    run_cycle(1'b0, 2, 0, 1, 2, 3, 0);
    if (rename_ready !== 1'b1) report_mismatch("ready after second flush", 1, rename_ready);
    close_test();
endtask

task automatic random_traffic();
    int unsigned r;
    int regs [4];
    open_test("random");
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
        r = next_rand();
        for (int j = 0; j < 4; j++) begin
            regs[j] = next_rand() % rename_pkg::ARF_DEPTH;
        end
        run_cycle(r % 23 == 0, (r >> 5) % 3, regs[0], regs[1], regs[2], regs[3], (r >> 8) % 3);
    end
    close_test();
endtask

`endif

// ==== verif/rename_tb.sv ====
`timescale 1ns/10ps

module rename_tb;

    localparam int unsigned LCG_SEED = 61;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_CYCLES = 300;

    logic                                  clk;
    logic                                  rst;
    logic                                  backend_flush;
    logic [rename_pkg::ID_WIDTH-1:0]       rename_valid;
    logic [rename_pkg::ARF_IDX-1:0]        rename_dest [rename_pkg::ID_WIDTH];
    logic [rename_pkg::ARF_IDX-1:0]        rename_src [rename_pkg::ID_WIDTH];
    logic [rename_pkg::ID_WIDTH-1:0]       commit_valid;
    logic [rename_pkg::ARF_IDX-1:0]        commit_arch [rename_pkg::ID_WIDTH];
    logic [rename_pkg::PRF_IDX-1:0]        commit_phys [rename_pkg::ID_WIDTH];
    logic                                  rename_ready;
    logic [rename_pkg::PRF_IDX-1:0]        rename_phys_dest [rename_pkg::ID_WIDTH];
    logic [rename_pkg::PRF_IDX-1:0]        rename_phys_src [rename_pkg::ID_WIDTH];
    logic [rename_pkg::PRF_IDX-1:0]        rename_stale [rename_pkg::ID_WIDTH];

    // reference model state.
    int model_free [$];
    int model_spec [rename_pkg::ARF_DEPTH];
    int model_arch [rename_pkg::ARF_DEPTH];
    int inflight_arch [$];
    int inflight_phys [$];

    int unsigned lcg_state = LCG_SEED;
    string cur_test;
    int test_errs;
    int tests_passed;
    int tests_failed;
    int cycle_count;

    rename_core dut (
        .clk              (clk),
        .rst              (rst),
        .backend_flush    (backend_flush),
        .rename_valid     (rename_valid),
        .rename_dest      (rename_dest),
        .rename_src       (rename_src),
        .commit_valid     (commit_valid),
        .commit_arch      (commit_arch),
        .commit_phys      (commit_phys),
        .rename_ready     (rename_ready),
        .rename_phys_dest (rename_phys_dest),
        .rename_phys_src  (rename_phys_src),
        .rename_stale     (rename_stale)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("** Error %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
        test_errs++;
    endtask

    // ====================================================================
    // one cycle of traffic against the model
    // ====================================================================

    task automatic run_cycle(input bit flush, input int nv, input int d0, input int d1,
                             input int s0, input int s1, input int nc_req);
        int nc;
        int used;
        int arch;
        bit exp_ready;
        logic [rename_pkg::ID_WIDTH-1:0] rv;
        int dst [rename_pkg::ID_WIDTH];
        int src [rename_pkg::ID_WIDTH];
        int exp_dest [rename_pkg::ID_WIDTH];
        int exp_src [rename_pkg::ID_WIDTH];
        int exp_stale [rename_pkg::ID_WIDTH];
        int tmp_map [rename_pkg::ARF_DEPTH];

        nc = (nc_req > inflight_arch.size()) ? inflight_arch.size() : nc_req;
        dst[0] = d0;
        dst[1] = d1;
        src[0] = s0;
        src[1] = s1;
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            rv[i] = (i < nv);
        end

        @(posedge clk);
        backend_flush <= flush;
        rename_valid <= rv;
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            rename_dest[i] <= rename_pkg::ARF_IDX'(dst[i]);
            rename_src[i] <= rename_pkg::ARF_IDX'(src[i]);
            commit_valid[i] <= (i < nc);
            if (i < nc) begin
                commit_arch[i] <= rename_pkg::ARF_IDX'(inflight_arch[i]);
                commit_phys[i] <= rename_pkg::PRF_IDX'(inflight_phys[i]);
            end
        end

        @(negedge clk);
        // younger lanes see older lanes' writes.
        tmp_map = model_spec;
        exp_ready = (model_free.size() >= nv);
        used = 0;
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            if (rv[i]) begin
                exp_src[i] = tmp_map[src[i]];
                exp_stale[i] = tmp_map[dst[i]];
                exp_dest[i] = (used < model_free.size()) ? model_free[used] : 0;
                tmp_map[dst[i]] = exp_dest[i];
                used++;
            end
        end
        if (rename_ready !== exp_ready) begin
            report_mismatch("rename_ready", exp_ready, rename_ready);
        end
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            if (exp_ready && rv[i]) begin
                if (rename_phys_dest[i] !== exp_dest[i]) begin
                    report_mismatch($sformatf("phys_dest[%0d]", i), exp_dest[i],
                                    rename_phys_dest[i]);
                end
                if (rename_phys_src[i] !== exp_src[i]) begin
                    report_mismatch($sformatf("phys_src[%0d]", i), exp_src[i],
                                    rename_phys_src[i]);
                end
                if (rename_stale[i] !== exp_stale[i]) begin
                    report_mismatch($sformatf("stale[%0d]", i), exp_stale[i], rename_stale[i]);
                end
            end
        end

        if (exp_ready && !flush) begin
            for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
                if (rv[i]) begin
                    model_spec[dst[i]] = model_free.pop_front();
                    inflight_arch.push_back(dst[i]);
                    inflight_phys.push_back(model_spec[dst[i]]);
                end
            end
        end
        for (int i = 0; i < nc; i++) begin
            arch = inflight_arch.pop_front();
            model_free.push_back(model_arch[arch]);
            model_arch[arch] = inflight_phys.pop_front();
        end
        // squashed registers go back ahead of the free ones.
        if (flush) begin
            model_free = {inflight_phys, model_free};
            inflight_arch.delete();
            inflight_phys.delete();
            model_spec = model_arch;
        end
    endtask

    `include "rename_tests.svh"

    initial begin
        rst = 1'b1;
        backend_flush = 1'b0;
        rename_valid = '0;
        commit_valid = '0;
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            rename_dest[i] = '0;
            rename_src[i] = '0;
            commit_arch[i] = '0;
            commit_phys[i] = '0;
        end
        for (int i = 0; i < rename_pkg::ARF_DEPTH; i++) begin
            model_spec[i] = i;
            model_arch[i] = i;
        end
        for (int i = 0; i < rename_pkg::FREELIST_DEPTH; i++) begin
            model_free.push_back(rename_pkg::ARF_DEPTH + i);
        end
        test_errs = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        check_reset_state();
        check_group_bypass();
        exhaust_free_list();
        commit_and_reuse();
        flush_recovery();
        random_traffic();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+verif
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/rename_table.sv
hdl/retire_table.sv
hdl/rename_core.sv
verif/rename_tb.sv

// ==== Makefile ====
# Verilator build and run for the rename core testbench.

VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= *** FAILED ***

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verif/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# rebuilt only when a source, a header or the file list changes.
$(BINARY): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	@./$(BINARY) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
